// File: build.f
design/csr_map_pkg.sv
design/hot_track_pkg.sv
design/hot_addr_convert.sv
design/hot_page_ring.sv
design/csr_regfile.sv
design/csr_access_fsm.sv
design/csr_tracker_top.sv
sim/csr_tracker_props.sv
sim/tb_csr_tracker.sv

// File: design/csr_access_fsm.sv
// CSR access FSM
// avalon style slave state machine. decodes the word address into a
// register, hot window or unmapped access, steers register writes and
// ring reads, builds the read word and drives waitrequest and
// readdatavalid
`timescale 1ns/1ps

module csr_access_fsm
   import csr_map_pkg::*, hot_track_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset_n,
   input  csr_req_t             bus_req_i,
   output csr_rsp_t             bus_rsp_o,
   output logic                 reg_wr_o,
   output logic [REG_IDX_W-1:0] reg_idx_o,
   output csr_word_t            reg_wdata_o,
   output logic [7:0]           reg_be_o,
   input  csr_word_t            reg_rdata_i,
   output logic                 hot_rd_o,
   output hot_idx_t             hot_idx_o,
   input  host_pfn_t            hot_data_i
);

   typedef enum logic [2:0] {
      IDLE,
      WRITE,
      READ_WAIT,
      READ_WAIT2,
      READ
   } state_t;

   state_t      state;
   state_t      next_state;
   csr_addr_u   waddr;
   logic        is_reg;
   logic        is_hot;
   logic        rd_start;
   logic        is_hot_q;
   logic [15:0] addr_lo_q;
   logic [7:0]  be_q;
   csr_word_t   rd_word;

   // ==============================
   // address decode
   // ==============================
   assign waddr  = bus_req_i.address[21:3];
   assign is_reg = (waddr.reg_view.upper == '0);
   assign is_hot = (waddr.hot_view.region == 7'(HOT_WINDOW_BASE / HOT_WINDOW_WORDS));

   // write wins when both strobes are up
   assign rd_start = (state == IDLE) && bus_req_i.read && !bus_req_i.write;

   // register port, write lands at the end of IDLE
   assign reg_wr_o    = (state == IDLE) && bus_req_i.write && is_reg;
   assign reg_idx_o   = waddr.reg_view.idx;
   assign reg_wdata_o = bus_req_i.writedata;
   assign reg_be_o    = bus_req_i.byteenable;

   // ring read, window index folded onto the ring depth
   assign hot_rd_o  = rd_start && is_hot;
   assign hot_idx_o = hot_idx_t'(waddr.hot_view.idx);

   // ==============================
   // state machine
   // ==============================
   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            if (bus_req_i.write) begin
               next_state = WRITE;
            end else if (bus_req_i.read) begin
               next_state = READ_WAIT;
            end
         end
         WRITE:      next_state = IDLE;
         // hot reads need one more cycle for the ring
         READ_WAIT:  next_state = is_hot_q ? READ_WAIT2 : READ;
         READ_WAIT2: next_state = READ;
         READ:       next_state = IDLE;
         default:    next_state = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state    <= IDLE;
         is_hot_q <= 1'b0;
      end else begin
         state <= next_state;
         if (rd_start) begin
            is_hot_q <= is_hot;
         end
      end
   end

   // ==============================
   // read word
   // ==============================
   always_ff @(posedge clk) begin
      if (rd_start) begin
         addr_lo_q <= bus_req_i.address[15:0];
         be_q      <= bus_req_i.byteenable;
         if (is_reg) begin
            rd_word <= reg_rdata_i & be_to_mask(bus_req_i.byteenable);
         end else begin
            // unmapped, pattern with the low address bits
            rd_word <= {UNMAPPED_HI, bus_req_i.address[15:0], UNMAPPED_LO}
                     & be_to_mask(bus_req_i.byteenable);
         end
      end else if (state == READ_WAIT2) begin
         // ring entry is stable since READ_WAIT
         rd_word <= {HOT_PAGE_TAG, addr_lo_q, hot_data_i} & be_to_mask(be_q);
      end
   end

   // response strobes straight from the state
   always_comb begin
      bus_rsp_o.readdata      = rd_word;
      bus_rsp_o.readdatavalid = (state == READ);
      bus_rsp_o.waitrequest   = !((state == WRITE) || (state == READ));
   end

endmodule

// File: design/csr_map_pkg.sv
// CSR map package
// register indices, bus request and response structs, control
// outputs and the decoded word address of the tracker CSR slave
package csr_map_pkg;

   // ==============================
   // register file layout
   // ==============================
   localparam int REGFILE_SIZE     = 32;
   // registers 0..7 are status, read only
   localparam int STATUS_SIZE      = 8;
   localparam int REG_IDX_W        = 5;
   localparam int CSR_ADDR_W       = 19;

   localparam int REG_MIG_COUNT    = 3;
   localparam int REG_MIG_LAST     = 5;
   localparam int REG_HOT_STATUS   = 6;
   localparam int REG_PAGE_RATE    = 8;
   localparam int REG_START_PA     = 10;
   localparam int REG_HOT_CLEAR    = 11;
   localparam int REG_ADDR_OFFSET  = 14;
   localparam int REG_ADDR_LB      = 15;
   localparam int REG_ADDR_UB      = 16;

   // hot page window, in 64-bit words
   localparam int HOT_WINDOW_BASE  = 4096;
   localparam int HOT_WINDOW_WORDS = 4096;

   // read tags and fill patterns
   localparam logic [15:0] HOT_PAGE_TAG  = 16'h7469;
   localparam logic [31:0] UNMAPPED_HI   = 32'hFEDCBA00;
   localparam logic [15:0] UNMAPPED_LO   = 16'hABCD;
   localparam logic [3:0]  LAST_PAGE_TAG = 4'h9;

   typedef logic [63:0] csr_word_t;

   // word address (bus bits 21..3), seen as register or hot window index
   typedef union packed {
      struct packed {
         logic [CSR_ADDR_W-REG_IDX_W-1:0] upper;
         logic [REG_IDX_W-1:0]            idx;
      } reg_view;
      struct packed {
         logic [6:0]  region;
         logic [11:0] idx;
      } hot_view;
   } csr_addr_u;

   // avalon style request from the host
   typedef struct packed {
      logic        read;
      logic        write;
      logic [31:0] address;
      csr_word_t   writedata;
      logic [7:0]  byteenable;
   } csr_req_t;

   typedef struct packed {
      csr_word_t readdata;
      logic      readdatavalid;
      logic      waitrequest;
   } csr_rsp_t;

   // control outputs toward the tracker
   typedef struct packed {
      logic [31:0] page_query_rate;
      csr_word_t   cxl_start_pa;
      csr_word_t   cxl_addr_offset;
      logic [32:0] addr_lb;
      logic [32:0] addr_ub;
   } csr_ctrl_t;

   // expand byteenable into a bit mask
   function automatic csr_word_t be_to_mask(input logic [7:0] be);
      csr_word_t m;
      for (int b = 0; b < 8; b++) begin
         m[8*b +: 8] = {8{be[b]}};
      end
      return m;
   endfunction

endpackage

// File: design/csr_regfile.sv
// CSR register file
// control registers 8..31 with byte masked writes, status registers
// for migration count, last frame and ring state, and the decode of
// registers into the tracker control outputs
`timescale 1ns/1ps

module csr_regfile
   import csr_map_pkg::*, hot_track_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset_n,
   input  logic                 wr_i,
   input  logic [REG_IDX_W-1:0] idx_i,
   input  csr_word_t            wdata_i,
   input  logic [7:0]           be_i,
   output csr_word_t            rdata_o,
   input  mig_evt_t             mig_evt_i,
   input  hot_idx_t             hot_wr_idx_i,
   input  logic                 hot_overflow_i,
   output logic                 hot_clear_o,
   output csr_ctrl_t            ctrl_o
);

   csr_word_t   regs [REGFILE_SIZE];
   csr_word_t   wr_masked;
   csr_word_t   mig_cnt;
   mig_pfn_t    last_pfn;
   logic [15:0] ovf_cnt;
   // index field of register 6 is 10 bits wide
   logic [9:0]  wr_idx_ext;

   assign wr_masked  = wdata_i & be_to_mask(be_i);
   assign wr_idx_ext = 10'(hot_wr_idx_i);

   // ==============================
   // event counters, first stage
   // ==============================
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         mig_cnt  <= '0;
         last_pfn <= '0;
         ovf_cnt  <= '0;
      end else begin
         // rejected frames are counted too
         if (mig_evt_i.en) begin
            mig_cnt  <= mig_cnt + 1'b1;
            last_pfn <= mig_evt_i.pfn;
         end
         if (hot_overflow_i) begin
            ovf_cnt <= ovf_cnt + 1'b1;
         end
      end
   end

   // ==============================
   // register array
   // ==============================
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < REGFILE_SIZE; i++) begin
            regs[i] <= '0;
         end
      end else begin
         // host writes, status range is skipped
         for (int i = STATUS_SIZE; i < REGFILE_SIZE; i++) begin
            if (wr_i && idx_i == REG_IDX_W'(i)) begin
               regs[i] <= wr_masked;
            end
         end
         // status snapshot, second stage
         regs[REG_MIG_COUNT]  <= mig_cnt;
         regs[REG_MIG_LAST]   <= {LAST_PAGE_TAG, last_pfn, 32'h0};
         regs[REG_HOT_STATUS] <= {ovf_cnt, 6'h0, wr_idx_ext, 32'h0};
      end
   end

   // combinational read, masked by the FSM
   assign rdata_o = regs[idx_i];

   // nonzero write to register 11 restarts the ring
   assign hot_clear_o = wr_i && (idx_i == REG_IDX_W'(REG_HOT_CLEAR)) && (wr_masked != '0);

   // control outputs
   always_comb begin
      ctrl_o.page_query_rate = regs[REG_PAGE_RATE][31:0];
      ctrl_o.cxl_start_pa    = regs[REG_START_PA];
      ctrl_o.cxl_addr_offset = regs[REG_ADDR_OFFSET];
      ctrl_o.addr_lb         = regs[REG_ADDR_LB][32:0];
      ctrl_o.addr_ub         = regs[REG_ADDR_UB][32:0];
   end

endmodule

// File: design/csr_tracker_top.sv
// CSR tracker top
// joins the migration path (converter, hot page ring) and the bus
// path (access FSM, register file) of the accelerator CSR slave
`timescale 1ns/1ps

module csr_tracker_top
   import csr_map_pkg::*, hot_track_pkg::*;
(
   input  logic      clk,
   input  logic      reset_n,
   input  csr_req_t  bus_req_i,
   output csr_rsp_t  bus_rsp_o,
   input  mig_evt_t  mig_evt_i,
   output csr_ctrl_t ctrl_o
);

   // converter to ring
   logic                 cvt_wr;
   host_pfn_t            cvt_pfn;
   // FSM to register file
   logic                 reg_wr;
   logic [REG_IDX_W-1:0] reg_idx;
   csr_word_t            reg_wdata;
   logic [7:0]           reg_be;
   csr_word_t            reg_rdata;
   // FSM to ring
   logic                 hot_rd;
   hot_idx_t             hot_idx;
   host_pfn_t            hot_data;
   // ring and register file
   hot_idx_t             hot_wr_idx;
   logic                 hot_overflow;
   logic                 hot_clear;

   // ==============================
   // migration path
   // ==============================
   hot_addr_convert i_convert (
      .clk        (clk),
      .reset_n    (reset_n),
      .mig_evt_i  (mig_evt_i),
      .start_pa_i (ctrl_o.cxl_start_pa),
      .offset_i   (ctrl_o.cxl_addr_offset),
      .hot_wr_o   (cvt_wr),
      .hot_pfn_o  (cvt_pfn)
   );

   hot_page_ring i_ring (
      .clk        (clk),
      .reset_n    (reset_n),
      .wr_i       (cvt_wr),
      .pfn_i      (cvt_pfn),
      .clear_i    (hot_clear),
      .rd_i       (hot_rd),
      .rd_idx_i   (hot_idx),
      .rd_data_o  (hot_data),
      .wr_idx_o   (hot_wr_idx),
      .overflow_o (hot_overflow)
   );

   // ==============================
   // bus path
   // ==============================
   csr_regfile i_regfile (
      .clk            (clk),
      .reset_n        (reset_n),
      .wr_i           (reg_wr),
      .idx_i          (reg_idx),
      .wdata_i        (reg_wdata),
      .be_i           (reg_be),
      .rdata_o        (reg_rdata),
      .mig_evt_i      (mig_evt_i),
      .hot_wr_idx_i   (hot_wr_idx),
      .hot_overflow_i (hot_overflow),
      .hot_clear_o    (hot_clear),
      .ctrl_o         (ctrl_o)
   );

   csr_access_fsm i_access (
      .clk         (clk),
      .reset_n     (reset_n),
      .bus_req_i   (bus_req_i),
      .bus_rsp_o   (bus_rsp_o),
      .reg_wr_o    (reg_wr),
      .reg_idx_o   (reg_idx),
      .reg_wdata_o (reg_wdata),
      .reg_be_o    (reg_be),
      .reg_rdata_i (reg_rdata),
      .hot_rd_o    (hot_rd),
      .hot_idx_o   (hot_idx),
      .hot_data_i  (hot_data)
   );

endmodule

// File: design/hot_addr_convert.sv
// hot address converter
// first stage of the migration path. drops the all-ones frame
// number, maps the frame into the 8 GB window with the host offset
// and rebases it onto the programmed start page. output registered
`timescale 1ns/1ps

module hot_addr_convert
   import csr_map_pkg::*, hot_track_pkg::*;
(
   input  logic      clk,
   input  logic      reset_n,
   input  mig_evt_t  mig_evt_i,
   input  csr_word_t start_pa_i,
   input  csr_word_t offset_i,
   output logic      hot_wr_o,
   output host_pfn_t hot_pfn_o
);

   logic                              pfn_ok;
   csr_word_t                         byte_addr;
   csr_word_t                         byte_sum;
   logic [WINDOW_BITS-1:0]            win_addr;
   logic [WINDOW_BITS-PAGE_SHIFT-1:0] win_page;
   host_pfn_t                         pfn_next;

   // all ones marks an invalid frame
   assign pfn_ok    = mig_evt_i.en && (mig_evt_i.pfn != '1);

   // frame to byte address
   assign byte_addr = csr_word_t'(mig_evt_i.pfn) << PAGE_SHIFT;
   assign byte_sum  = byte_addr + offset_i;

   // wrap into the 8 GB window
   assign win_addr  = byte_sum[WINDOW_BITS-1:0];
   assign win_page  = win_addr[WINDOW_BITS-1:PAGE_SHIFT];

   // back to a page number, plus start page, 32 bit result
   assign pfn_next  = host_pfn_t'(win_page)
                    + start_pa_i[PAGE_SHIFT +: $bits(host_pfn_t)];

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         hot_wr_o <= 1'b0;
      end else begin
         hot_wr_o <= pfn_ok;
      end
   end

   // payload only moves with a valid event
   always_ff @(posedge clk) begin
      if (pfn_ok) begin
         hot_pfn_o <= pfn_next;
      end
   end

endmodule

// File: design/hot_page_ring.sv
// hot page ring
// circular buffer of host page numbers. the write index advances on
// each store and wraps at the last entry, pulsing overflow. an index
// clear wins over a store. reads return one cycle after the strobe
`timescale 1ns/1ps

module hot_page_ring
   import hot_track_pkg::*;
(
   input  logic      clk,
   input  logic      reset_n,
   input  logic      wr_i,
   input  host_pfn_t pfn_i,
   input  logic      clear_i,
   input  logic      rd_i,
   input  hot_idx_t  rd_idx_i,
   output host_pfn_t rd_data_o,
   output hot_idx_t  wr_idx_o,
   output logic      overflow_o
);

   host_pfn_t mem [HOT_DEPTH];
   hot_idx_t  wr_idx;
   logic      store;
   logic      at_last;

   // a clear in the same cycle drops the store
   assign store   = wr_i && !clear_i;
   assign at_last = (wr_idx == hot_idx_t'(HOT_DEPTH - 1));

   // ==============================
   // write index and overflow
   // ==============================
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_idx     <= '0;
         overflow_o <= 1'b0;
      end else begin
         overflow_o <= 1'b0;
         if (clear_i) begin
            wr_idx <= '0;
         end else if (wr_i) begin
            if (at_last) begin
               // wrap, oldest entries get overwritten
               wr_idx     <= '0;
               overflow_o <= 1'b1;
            end else begin
               wr_idx <= wr_idx + 1'b1;
            end
         end
      end
   end

   // ==============================
   // storage
   // ==============================
   always_ff @(posedge clk) begin
      if (store) begin
         mem[wr_idx] <= pfn_i;
      end
   end

   // registered read port
   always_ff @(posedge clk) begin
      if (rd_i) begin
         rd_data_o <= mem[rd_idx_i];
      end
   end

   assign wr_idx_o = wr_idx;

endmodule

// File: design/hot_track_pkg.sv
// hot page tracker package
// page number types, migration event, ring depth and the
// shift constants of the frame number conversion
package hot_track_pkg;

   // ring depth, any power of two up to 1024
   localparam int HOT_DEPTH   = 64;
   localparam int HOT_IDX_W   = $clog2(HOT_DEPTH);

   // 4 KB pages
   localparam int PAGE_SHIFT  = 12;
   // device window of 8 GB
   localparam int WINDOW_BITS = 33;

   typedef logic [HOT_IDX_W-1:0] hot_idx_t;

   // frame number reported by the tracker
   typedef logic [27:0] mig_pfn_t;

   // page number in host address space
   typedef logic [31:0] host_pfn_t;

   typedef struct packed {
      logic     en;
      mig_pfn_t pfn;
   } mig_evt_t;

endpackage

// File: sim/csr_tracker_props.sv
// bus response checks
// concurrent assertions on the avalon style response of the
// access FSM, bound into every csr_access_fsm instance
`timescale 1ns/1ps

module csr_tracker_props
   import csr_map_pkg::*;
(
   input logic     clk,
   input logic     reset_n,
   input csr_rsp_t rsp_i
);

   // number of failed assertions
   int unsigned fail_cnt = 0;

   // ==============================
   // response strobes
   // ==============================
   // data only comes in the accept cycle
   rdv_no_wait: assert property (@(posedge clk) disable iff (!reset_n)
      rsp_i.readdatavalid |-> !rsp_i.waitrequest)
   else begin
      fail_cnt++;
      $error("readdatavalid while waitrequest is high");
   end

   // no back-pressure means one cycle of valid data
   rdv_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
      rsp_i.readdatavalid |=> !rsp_i.readdatavalid)
   else begin
      fail_cnt++;
      $error("readdatavalid held for two cycles");
   end

   // FSM sits in IDLE once reset has been sampled
   rst_idle: assert property (@(posedge clk)
      !reset_n |=> (rsp_i.waitrequest && !rsp_i.readdatavalid))
   else begin
      fail_cnt++;
      $error("response strobes not idle during reset");
   end

endmodule

bind csr_access_fsm csr_tracker_props i_props (
   .clk     (clk),
   .reset_n (reset_n),
   .rsp_i   (bus_rsp_o)
);

// File: sim/csr_tracker_stim.txt
# op addr data be expected, hex. W write, R read and compare, C ctrl_o field (addr = register)
# M events (addr = first frame, data = count), I idle (addr = cycles)
W 00000040 1122334455667788 0F 0000000000000000
C 00000008 0000000000000000 00 0000000055667788
R 00000040 0000000000000000 FF 0000000055667788
W 00000078 AAAABBBBCCCCDDDD 31 0000000000000000
C 0000000F 0000000000000000 00 00000001000000DD
R 00000078 0000000000000000 F0 0000BBBB00000000
R 00000078 0000000000000000 FF 0000BBBB000000DD
W 00000080 00000001FFFFF000 FF 0000000000000000
C 00000010 0000000000000000 00 00000001FFFFF000
W 00000038 FFFFFFFFFFFFFFFF FF 0000000000000000
R 00000038 0000000000000000 FF 0000000000000000
W 00000050 0000000100000000 FF 0000000000000000
C 0000000A 0000000000000000 00 0000000100000000
W 00000070 0000000040000000 FF 0000000000000000
C 0000000E 0000000000000000 00 0000000040000000
M 00000123 0000000000000001 00 0000000000000000
M 0FFFFFFE 0000000000000001 00 0000000000000000
M 0FFFFFFF 0000000000000001 00 0000000000000000
M 001C0000 0000000000000001 00 0000000000000000
I 00000004 0000000000000000 00 0000000000000000
R 00008000 0000000000000000 FF 7469800000140123
R 00008008 0000000000000000 FF 746980080013FFFE
R 00008010 0000000000000000 FF 7469801000100000
R 00000018 0000000000000000 FF 0000000000000004
R 00000028 0000000000000000 FF 901C000000000000
R 00000030 0000000000000000 FF 0000000300000000
M 00000200 000000000000003E 00 0000000000000000
I 00000004 0000000000000000 00 0000000000000000
R 000081F8 0000000000000000 FF 746981F80014023C
R 00008200 0000000000000000 FF 746982000014023D
R 00000028 0000000000000000 FF 9000023D00000000
R 00000030 0000000000000000 FF 0001000100000000
W 00000058 0000000000000001 FF 0000000000000000
M 00000005 0000000000000002 00 0000000000000000
I 00000004 0000000000000000 00 0000000000000000
R 00008000 0000000000000000 FF 7469800000140005
R 00000030 0000000000000000 FF 0001000200000000
R 00001238 0000000000000000 FF FEDCBA001238ABCD
R 00200010 0000000000000000 F0 FEDCBA0000000000

// File: sim/tb_csr_tracker.sv
// CSR tracker testbench
// reads bus and migration records from the stimulus file, drives the
// DUT and compares read data and control outputs with the expected
// words of each record. reset state and a register sweep come first
`timescale 1ns/1ps

module tb_csr_tracker
   import csr_map_pkg::*, hot_track_pkg::*;
();

   // one line of the stimulus file
   typedef struct packed {
      logic [7:0]  op;
      logic [31:0] addr;
      csr_word_t   data;
      logic [7:0]  be;
      csr_word_t   expv;
   } stim_rec_t;

   logic        clk;
   logic        reset_n;
   csr_req_t    bus_req;
   csr_rsp_t    bus_rsp;
   mig_evt_t    mig_evt;
   csr_ctrl_t   ctrl;
   csr_ctrl_t   exp_ctrl;
   stim_rec_t   recs[$];
   int unsigned cycle_cnt   = 0;
   int unsigned cycle_limit = 0;

   csr_tracker_top i_dut (
      .clk       (clk),
      .reset_n   (reset_n),
      .bus_req_i (bus_req),
      .bus_rsp_o (bus_rsp),
      .mig_evt_i (mig_evt),
      .ctrl_o    (ctrl)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ==============================
   // run limit and assertion watch
   // ==============================
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (i_dut.i_access.i_props.fail_cnt != 0) begin
         $display("a bus response assertion failed before %0t ns", $time);
         $display("Regression failed");
         $fatal(1, "assertion failure");
      end else if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Regression failed");
         $fatal(1, "run limit reached");
      end
   end

   // ==============================
   // reporting and compares
   // ==============================
   task automatic stop_on_error(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      $display("Regression failed");
      $fatal(1, "stopped at first mismatch");
   endtask

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Regression failed");
      $fatal(1, "run aborted");
   endtask

   task automatic check_word(input csr_word_t got, input csr_word_t exp, input string what);
      if (got !== exp) begin
         stop_on_error($sformatf("%s: got %h, expected %h", what, got, exp));
      end
   endtask

   // waitrequest and readdatavalid only
   task automatic check_rsp(input csr_rsp_t got, input csr_rsp_t exp, input string what);
      if (got.waitrequest !== exp.waitrequest || got.readdatavalid !== exp.readdatavalid) begin
         stop_on_error($sformatf("%s: waitrequest %b readdatavalid %b", what,
                                 got.waitrequest, got.readdatavalid));
      end
   endtask

   task automatic check_ctrl(input csr_ctrl_t got, input csr_ctrl_t exp, input string what);
      if (got !== exp) begin
         stop_on_error($sformatf("%s: got %h, expected %h", what, got, exp));
      end
   endtask

   // ==============================
   // stimulus
   // ==============================
   task automatic load_stim();
      int          fd;
      int          n;
      string       line;
      stim_rec_t   rec;
      logic [7:0]  op_c;
      logic [31:0] a;
      csr_word_t   d;
      logic [7:0]  b;
      csr_word_t   e;
      fd = $fopen("sim/csr_tracker_stim.txt", "r");
      if (fd == 0) begin
         abort_run("cannot open the stimulus file sim/csr_tracker_stim.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         // skip blank and comment lines
         if (line.len() > 1 && line[0] != "#") begin
            n = $sscanf(line, "%c %h %h %h %h", op_c, a, d, b, e);
            if (n != 5) begin
               abort_run($sformatf("malformed stimulus line: %s", line));
            end
            rec.op   = op_c;
            rec.addr = a;
            rec.data = d;
            rec.be   = b;
            rec.expv = e;
            recs.push_back(rec);
         end
      end
      $fclose(fd);
   endtask

   // hold write until waitrequest drops
   task automatic bus_write(input logic [31:0] addr, input csr_word_t data,
                            input logic [7:0] be);
      @(posedge clk);
      bus_req.write      <= 1'b1;
      bus_req.address    <= addr;
      bus_req.writedata  <= data;
      bus_req.byteenable <= be;
      do @(negedge clk); while (bus_rsp.waitrequest);
      @(posedge clk);
      bus_req.write <= 1'b0;
   endtask

   task automatic bus_read(input logic [31:0] addr, input logic [7:0] be,
                           output csr_word_t data);
      @(posedge clk);
      bus_req.read       <= 1'b1;
      bus_req.address    <= addr;
      bus_req.byteenable <= be;
      do @(negedge clk); while (!bus_rsp.readdatavalid);
      data = bus_rsp.readdata;
      @(posedge clk);
      bus_req.read <= 1'b0;
   endtask

   // back to back events with frame numbers counting up
   task automatic send_events(input mig_pfn_t first, input int count);
      for (int n = 0; n < count; n++) begin
         @(posedge clk);
         mig_evt.en  <= 1'b1;
         mig_evt.pfn <= first + mig_pfn_t'(n);
      end
      @(posedge clk);
      mig_evt.en <= 1'b0;
   endtask

   // one ctrl_o field changes per record and the rest must hold
   task automatic expect_ctrl(input int idx, input csr_word_t val);
      case (idx)
         REG_PAGE_RATE:   exp_ctrl.page_query_rate = val[31:0];
         REG_START_PA:    exp_ctrl.cxl_start_pa    = val;
         REG_ADDR_OFFSET: exp_ctrl.cxl_addr_offset = val;
         REG_ADDR_LB:     exp_ctrl.addr_lb         = val[32:0];
         REG_ADDR_UB:     exp_ctrl.addr_ub         = val[32:0];
         default: abort_run($sformatf("register %0d drives no control output", idx));
      endcase
      @(negedge clk);
      check_ctrl(ctrl, exp_ctrl, $sformatf("ctrl_o after register %0d", idx));
   endtask

   // ==============================
   // main sequence
   // ==============================
   initial begin
      csr_word_t rd_data;
      csr_word_t exp_word;
      csr_rsp_t  exp_rsp;
      stim_rec_t rec;
      void'($urandom(22407));
      reset_n  = 1'b0;
      bus_req  = '0;
      mig_evt  = '0;
      exp_ctrl = '0;
      load_stim();
      cycle_limit = 20 * recs.size() + 2000;

      repeat (16) @(posedge clk);
      reset_n <= 1'b1;
      @(negedge clk);
      exp_rsp             = '0;
      exp_rsp.waitrequest = 1'b1;
      check_rsp(bus_rsp, exp_rsp, "response after reset");

      // all registers clear except the tag of register 5
      for (int i = 0; i < REGFILE_SIZE; i++) begin
         exp_word = (i == REG_MIG_LAST) ? {LAST_PAGE_TAG, 60'h0} : '0;
         bus_read(32'(i * 8), 8'hFF, rd_data);
         check_word(rd_data, exp_word, $sformatf("register %0d after reset", i));
      end

      foreach (recs[k]) begin
         rec = recs[k];
         repeat ($urandom_range(3)) @(posedge clk);
         case (rec.op)
            "W": bus_write(rec.addr, rec.data, rec.be);
            "R": begin
               bus_read(rec.addr, rec.be, rd_data);
               check_word(rd_data, rec.expv, $sformatf("record %0d, read of %h", k, rec.addr));
            end
            "M": send_events(mig_pfn_t'(rec.addr), int'(rec.data));
            "C": expect_ctrl(int'(rec.addr), rec.expv);
            "I": repeat (rec.addr) @(posedge clk);
            default: abort_run($sformatf("unknown opcode in stimulus record %0d", k));
         endcase
      end

      repeat (4) @(posedge clk);
      if (i_dut.i_access.i_props.fail_cnt == 0) begin
         $display("Regression passed");
         $finish;
      end else begin
         $display("%0d bus response assertions failed", i_dut.i_access.i_props.fail_cnt);
         $display("Regression failed");
         $fatal(1, "assertion failures");
      end
   end

endmodule
